//--- source/dac_pkg.sv
////////////////////////////////////////
// shared types and constants for the AD5601 control block
////////////////////////////////////////

`default_nettype none

package dac_pkg;

    ////////////////////////////////////////
    // frame and field geometry

    // one AD5601 shift word
    localparam int dac_frame_bits = 16;

    // gain input and data field of the DAC word
    localparam int gain_width = 8;
    localparam int data_lsb   = 6;

    // read-only version register contents
    localparam logic [15:0] module_version = 16'd1;

    ////////////////////////////////////////
    // types

    // 16-bit word shifted out to the DAC
    typedef logic [dac_frame_bits-1:0] dac_word_t;

    // register map addresses, 4..15 are undefined and read as zero
    typedef enum logic [3:0] {
        reg_module_id      = 4'd0,
        reg_module_version = 4'd1,
        reg_dac            = 4'd2,
        reg_mmi_ctrl       = 4'd3
    } reg_addr_t;

    // power mode field, bits 15..14 of the DAC word
    typedef enum logic [1:0] {
        mode_normal      = 2'b00,
        mode_pd_1k       = 2'b01,
        mode_pd_100k     = 2'b10,
        mode_three_state = 2'b11
    } power_mode_t;

    // update sequencer states
    typedef enum logic [1:0] {
        seq_idle,
        seq_start_after_reset,
        seq_transfer
    } seq_state_t;

endpackage

`default_nettype wire

//--- source/dac_reg_map.sv
////////////////////////////////////////
// register file with host bus decode, DAC word ownership
// and change strobe
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dac_reg_map #(
    parameter logic [15:0]        module_id   = 16'h0000,
    parameter dac_pkg::dac_word_t dac_default = '0
) (
    input  logic                              clk_ifc,
    input  logic                              SET_DEFAULT_ON_RESET,

    input  logic                              mmi_ctrl_en,

    // host write side
    input  logic                              wr_stb,
    input  dac_pkg::reg_addr_t                wr_addr,
    input  dac_pkg::dac_word_t                wr_data,

    // host read side
    input  logic                              rd_stb,
    input  logic [3:0]                        rd_addr,
    output dac_pkg::dac_word_t                rd_data,
    output logic                              rd_valid,

    // local gain source
    input  logic [dac_pkg::gain_width-1:0]    gain,
    input  logic                              gain_valid_stb,

    output dac_pkg::dac_word_t                dac_word,
    output logic                              dac_change_stb
);

    import dac_pkg::*;

    ////////////////////////////////////////
    // signals

    dac_word_t   dac_word_q;
    dac_word_t   gain_word;
    power_mode_t cur_mode;
    logic        mmi_ctrl_q;
    logic        host_wr_ok;
    logic        gain_wr_ok;

    ////////////////////////////////////////
    // decode

    // host owns the word while the enable level is high
    assign host_wr_ok = wr_stb && (wr_addr == reg_dac) && mmi_ctrl_en;

    // otherwise the gain strobe owns the data field
    assign gain_wr_ok = gain_valid_stb && !mmi_ctrl_en;

    // keep mode and reserved bits, replace only the data field
    assign cur_mode  = power_mode_t'(dac_word_q[dac_frame_bits-1 -: 2]);
    assign gain_word = {cur_mode, gain, dac_word_q[data_lsb-1:0]};

    assign dac_word = dac_word_q;

    ////////////////////////////////////////
    // DAC word register

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            dac_word_q     <= dac_default;
            dac_change_stb <= 1'b0;
        end else begin
            dac_change_stb <= host_wr_ok || gain_wr_ok;
            if (host_wr_ok) begin
                dac_word_q <= wr_data;
            end else if (gain_wr_ok) begin
                dac_word_q <= gain_word;
            end
        end
    end

    // registered copy of the enable level for readback
    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            mmi_ctrl_q <= 1'b0;
        end else begin
            mmi_ctrl_q <= mmi_ctrl_en;
        end
    end

    ////////////////////////////////////////
    // read path, fixed one cycle latency

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_stb;
        end
    end

    // register read mux
    always_ff @(posedge clk_ifc) begin
        if (rd_stb) begin
            case (rd_addr)
                reg_module_id: begin
                    rd_data <= module_id;
                end
                reg_module_version: begin
                    rd_data <= module_version;
                end
                reg_dac: begin
                    rd_data <= dac_word_q;
                end
                reg_mmi_ctrl: begin
                    rd_data <= {{(dac_frame_bits-1){1'b0}}, mmi_ctrl_q};
                end
                default: begin
                    // undefined address
                    rd_data <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/dac_update_sequencer.sv
////////////////////////////////////////
// update sequencer: launches, merges and reports SPI frames
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dac_update_sequencer #(
    parameter bit load_default_at_reset = 1'b1
) (
    input  logic               clk_ifc,
    input  logic               SET_DEFAULT_ON_RESET,

    // from the register map
    input  dac_pkg::dac_word_t dac_word,
    input  logic               dac_change_stb,

    // to the shift master
    output logic               frame_start,
    output dac_pkg::dac_word_t frame_word,
    input  logic               busy,
    input  logic               frame_done,

    output logic               dac_updated_stb,
    output logic               init_done
);

    import dac_pkg::*;

    ////////////////////////////////////////
    // signals

    seq_state_t state;

    // a change arrived while a frame was in flight
    logic pending;

    // launch is allowed only when the shift master is free
    logic can_launch;

    assign can_launch = !busy;

    ////////////////////////////////////////
    // control FSM

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            state           <= load_default_at_reset ? seq_start_after_reset : seq_idle;
            pending         <= 1'b0;
            frame_start     <= 1'b0;
            dac_updated_stb <= 1'b0;
        end else begin
            frame_start     <= 1'b0;
            dac_updated_stb <= 1'b0;

            case (state)
                seq_idle: begin
                    if (dac_change_stb && can_launch) begin
                        frame_start <= 1'b1;
                        state       <= seq_transfer;
                    end
                end

                seq_start_after_reset: begin
                    // send the default word once
                    frame_start <= 1'b1;
                    state       <= seq_transfer;
                    if (dac_change_stb) begin
                        pending <= 1'b1;
                    end
                end

                seq_transfer: begin
                    if (dac_change_stb) begin
                        pending <= 1'b1;
                    end
                    if (frame_done) begin
                        dac_updated_stb <= 1'b1;
                        if (pending || dac_change_stb) begin
                            // one follow-up frame carries the latest word
                            frame_start <= 1'b1;
                            pending     <= 1'b0;
                        end else begin
                            state <= seq_idle;
                        end
                    end
                end

                default: begin
                    state   <= seq_idle;
                    pending <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // frame payload

    // word is sampled whenever a launch is issued
    always_ff @(posedge clk_ifc) begin
        if (state == seq_start_after_reset) begin
            frame_word <= dac_word;
        end else if (state == seq_idle && dac_change_stb) begin
            frame_word <= dac_word;
        end else if (state == seq_transfer && frame_done) begin
            frame_word <= dac_word;
        end
    end

    ////////////////////////////////////////
    // init done

    // high after the first completed frame when the default is loaded
    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            init_done <= ~load_default_at_reset;
        end else if (state == seq_transfer && frame_done) begin
            init_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/spi_shift_master.sv
////////////////////////////////////////
// 16-bit AD5601 serializer with sclk divider and sync_n framing
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_shift_master #(
    parameter int sclk_half_cycles = 2
) (
    input  logic               clk_ifc,
    input  logic               SET_DEFAULT_ON_RESET,

    input  logic               frame_start,
    input  dac_pkg::dac_word_t frame_word,
    output logic               busy,
    output logic               frame_done,

    // AD5601 serial pins
    output logic               sclk,
    output logic               sync_n,
    output logic               sdin
);

    import dac_pkg::*;

    ////////////////////////////////////////
    // counters

    localparam int div_w = (sclk_half_cycles > 1) ? $clog2(sclk_half_cycles) : 1;
    localparam int bit_w = $clog2(dac_frame_bits);

    localparam logic [div_w-1:0] div_last = div_w'(sclk_half_cycles - 1);
    localparam logic [bit_w-1:0] bit_last = bit_w'(dac_frame_bits - 1);

    logic [div_w-1:0] div_cnt;
    logic [bit_w-1:0] bit_cnt;
    dac_word_t        shreg;
    logic             half_end;

    assign half_end = (div_cnt == div_last);

    // MSB first, moves on the rising sclk edge
    assign sdin = shreg[dac_frame_bits-1];

    ////////////////////////////////////////
    // frame engine

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            busy       <= 1'b0;
            frame_done <= 1'b0;
            sclk       <= 1'b1;
            sync_n     <= 1'b1;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            shreg      <= '0;
        end else begin
            frame_done <= 1'b0;
            if (frame_start && !busy) begin
                busy    <= 1'b1;
                sync_n  <= 1'b0;
                sclk    <= 1'b1;
                div_cnt <= '0;
                bit_cnt <= '0;
                shreg   <= frame_word;
            end else if (busy) begin
                if (!half_end) begin
                    div_cnt <= div_cnt + 1'b1;
                end else begin
                    div_cnt <= '0;
                    if (sclk) begin
                        // falling edge, DAC samples sdin here
                        sclk <= 1'b0;
                    end else if (bit_cnt == bit_last) begin
                        // last low half done, close the frame
                        sclk       <= 1'b1;
                        sync_n     <= 1'b1;
                        busy       <= 1'b0;
                        frame_done <= 1'b1;
                    end else begin
                        sclk    <= 1'b1;
                        bit_cnt <= bit_cnt + 1'b1;
                        shreg   <= {shreg[dac_frame_bits-2:0], 1'b0};
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dac_ad5601_subsystem.sv
////////////////////////////////////////
// AD5601 control block top level
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dac_ad5601_subsystem #(
    parameter logic [15:0]        module_id             = 16'h0000,
    parameter dac_pkg::dac_word_t dac_default           = '0,
    parameter bit                 load_default_at_reset = 1'b1,
    parameter int                 sclk_half_cycles      = 2
) (
    input  logic                           clk_ifc,
    input  logic                           SET_DEFAULT_ON_RESET,

    input  logic                           mmi_ctrl_en,

    // host bus
    input  logic                           wr_stb,
    input  dac_pkg::reg_addr_t             wr_addr,
    input  dac_pkg::dac_word_t             wr_data,
    input  logic                           rd_stb,
    input  logic [3:0]                     rd_addr,
    output dac_pkg::dac_word_t             rd_data,
    output logic                           rd_valid,

    // gain path
    input  logic [dac_pkg::gain_width-1:0] gain,
    input  logic                           gain_valid_stb,

    output logic                           dac_updated_stb,
    output logic                           init_done,

    // AD5601 pins
    output logic                           sclk,
    output logic                           sync_n,
    output logic                           sdin
);

    import dac_pkg::*;

    dac_word_t dac_word;
    logic      dac_change_stb;
    logic      frame_start;
    dac_word_t frame_word;
    logic      busy;
    logic      frame_done;

    dac_reg_map #(
        .module_id   (module_id),
        .dac_default (dac_default)
    ) u_reg_map (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .mmi_ctrl_en          (mmi_ctrl_en),
        .wr_stb               (wr_stb),
        .wr_addr              (wr_addr),
        .wr_data              (wr_data),
        .rd_stb               (rd_stb),
        .rd_addr              (rd_addr),
        .rd_data              (rd_data),
        .rd_valid             (rd_valid),
        .gain                 (gain),
        .gain_valid_stb       (gain_valid_stb),
        .dac_word             (dac_word),
        .dac_change_stb       (dac_change_stb)
    );

    dac_update_sequencer #(
        .load_default_at_reset (load_default_at_reset)
    ) u_sequencer (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .dac_word             (dac_word),
        .dac_change_stb       (dac_change_stb),
        .frame_start          (frame_start),
        .frame_word           (frame_word),
        .busy                 (busy),
        .frame_done           (frame_done),
        .dac_updated_stb      (dac_updated_stb),
        .init_done            (init_done)
    );

    spi_shift_master #(
        .sclk_half_cycles (sclk_half_cycles)
    ) u_spi (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .frame_start          (frame_start),
        .frame_word           (frame_word),
        .busy                 (busy),
        .frame_done           (frame_done),
        .sclk                 (sclk),
        .sync_n               (sync_n),
        .sdin                 (sdin)
    );

endmodule

`default_nettype wire

//--- verification/dac_tb_assert.sv
////////////////////////////////////////
// bound checks on SPI framing, launches and update strobes
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dac_tb_assert #(
    parameter int frame_cycles = 32
) (
    input logic                clk_ifc,
    input logic                SET_DEFAULT_ON_RESET,
    input logic                frame_start,
    input logic                busy,
    input logic                sync_n,
    input logic                updated_stb,
    input dac_pkg::seq_state_t state
);

    import dac_pkg::*;

    int error_count = 0;
    int low_cnt;

    // length of the current sync_n low phase
    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET || sync_n) begin
            low_cnt <= 0;
        end else begin
            low_cnt <= low_cnt + 1;
        end
    end

    frame_length_a: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        $rose(sync_n) |-> (low_cnt == frame_cycles))
        else begin
            error_count = error_count + 1;
            $error("sync_n low phase was %0d cycles", low_cnt);
        end

    start_idle_a: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        frame_start |-> !busy)
        else begin
            error_count = error_count + 1;
            $error("frame_start while the shift master is busy");
        end

    // the shift master is free whenever the sequencer is idle
    idle_free_a: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        (state == seq_idle) |-> !busy)
        else begin
            error_count = error_count + 1;
            $error("sequencer idle while the shift master is busy");
        end

    updated_pulse_a: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        updated_stb |=> !updated_stb)
        else begin
            error_count = error_count + 1;
            $error("dac_updated_stb longer than one cycle");
        end

endmodule

bind spi_shift_master dac_tb_assert #(
    .frame_cycles (2 * dac_pkg::dac_frame_bits * sclk_half_cycles)
) spi_checks (
    .clk_ifc              (clk_ifc),
    .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
    .frame_start          (frame_start),
    .busy                 (busy),
    .sync_n               (sync_n),
    .updated_stb          (1'b0),
    .state                (dac_pkg::seq_transfer)
);

bind dac_update_sequencer dac_tb_assert seq_checks (
    .clk_ifc              (clk_ifc),
    .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
    .frame_start          (frame_start),
    .busy                 (busy),
    .sync_n               (1'b1),
    .updated_stb          (dac_updated_stb),
    .state                (state)
);

`default_nettype wire

//--- verification/dac_tb.sv
////////////////////////////////////////
// directed testbench for the AD5601 control block
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dac_tb;

    import dac_pkg::*;

    localparam logic [15:0] tb_module_id   = 16'h0D5A;
    localparam dac_word_t   tb_dac_default = 16'h4AC0;
    localparam int          tb_sclk_half   = 2;
    localparam int          timeout_cycles = 300;

    logic                  clk_ifc;
    logic                  SET_DEFAULT_ON_RESET;
    logic                  mmi_ctrl_en;
    logic                  wr_stb;
    reg_addr_t             wr_addr;
    dac_word_t             wr_data;
    logic                  rd_stb;
    logic [3:0]            rd_addr;
    dac_word_t             rd_data;
    logic                  rd_valid;
    logic [gain_width-1:0] gain;
    logic                  gain_valid_stb;
    logic                  dac_updated_stb;
    logic                  init_done;
    logic                  sclk;
    logic                  sync_n;
    logic                  sdin;

    integer    seed = 32'hffc;
    dac_word_t frames[$];
    dac_word_t cap_word = '0;
    int        cap_bits = 0;

    dac_ad5601_subsystem #(
        .module_id             (tb_module_id),
        .dac_default           (tb_dac_default),
        .load_default_at_reset (1'b1),
        .sclk_half_cycles      (tb_sclk_half)
    ) UUT (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .mmi_ctrl_en          (mmi_ctrl_en),
        .wr_stb               (wr_stb),
        .wr_addr              (wr_addr),
        .wr_data              (wr_data),
        .rd_stb               (rd_stb),
        .rd_addr              (rd_addr),
        .rd_data              (rd_data),
        .rd_valid             (rd_valid),
        .gain                 (gain),
        .gain_valid_stb       (gain_valid_stb),
        .dac_updated_stb      (dac_updated_stb),
        .init_done            (init_done),
        .sclk                 (sclk),
        .sync_n               (sync_n),
        .sdin                 (sdin)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #5 clk_ifc = ~clk_ifc;
    end

    // the DAC samples sdin on the falling sclk edge, MSB first
    always @(negedge sclk) begin
        if (sync_n == 1'b0) begin
            cap_word = {cap_word[dac_frame_bits-2:0], sdin};
            cap_bits = cap_bits + 1;
            if (cap_bits == dac_frame_bits) begin
                frames.push_back(cap_word);
                cap_bits = 0;
            end
        end
    end

    ////////////////////////////////////////
    // reporting and compare tasks

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_word(input string name, input dac_word_t expected,
                                input dac_word_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // any bound assertion failure ends the run here
    always @(negedge clk_ifc) begin
        if (UUT.u_spi.spi_checks.error_count != 0 ||
            UUT.u_sequencer.seq_checks.error_count != 0) begin
            $display("a bound SPI or sequencer assertion failed");
            abort_run();
        end
    end

    ////////////////////////////////////////
    // bus, gain and wait tasks

    task automatic bus_write(input reg_addr_t addr, input dac_word_t data);
        @(negedge clk_ifc);
        wr_stb  = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk_ifc);
        wr_stb = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output dac_word_t data);
        @(negedge clk_ifc);
        rd_stb  = 1'b1;
        rd_addr = addr;
        compare_bit("rd_valid before strobe", 1'b0, rd_valid);
        @(negedge clk_ifc);
        rd_stb = 1'b0;
        compare_bit("rd_valid one cycle after strobe", 1'b1, rd_valid);
        data = rd_data;
        @(negedge clk_ifc);
        compare_bit("rd_valid single cycle", 1'b0, rd_valid);
    endtask

    task automatic gain_pulse(input logic [gain_width-1:0] value);
        @(negedge clk_ifc);
        gain           = value;
        gain_valid_stb = 1'b1;
        @(negedge clk_ifc);
        gain_valid_stb = 1'b0;
    endtask

    task automatic set_owner(input logic host_owns);
        @(negedge clk_ifc);
        mmi_ctrl_en = host_owns;
    endtask

    task automatic wait_updated();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < timeout_cycles; i++) begin
            @(negedge clk_ifc);
            if (dac_updated_stb) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            $display("timed out waiting for dac_updated_stb");
            abort_run();
        end
    endtask

    task automatic wait_frame_active();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < timeout_cycles; i++) begin
            @(negedge clk_ifc);
            if (!sync_n) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            $display("timed out waiting for sync_n to go low");
            abort_run();
        end
    endtask

    // nothing may reach the DAC during this window
    task automatic check_no_update(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk_ifc);
            if (dac_updated_stb || !sync_n) begin
                $display("an SPI frame started although no update was expected");
                abort_run();
            end
        end
    endtask

    function automatic dac_word_t random_word();
        integer rnd;
        rnd = $random(seed);
        return rnd[15:0];
    endfunction

    ////////////////////////////////////////
    // directed tests

    task automatic test_reset_default();
        compare_bit("reset init_done before first frame", 1'b0, init_done);
        compare_bit("reset sclk idle level", 1'b1, sclk);
        compare_bit("reset sync_n idle level", 1'b1, sync_n);
        compare_count("reset frames before default", 0, frames.size());
        wait_updated();
        compare_bit("reset init_done after first frame", 1'b1, init_done);
        compare_count("reset default frame count", 1, frames.size());
        compare_word("reset default frame", tb_dac_default, frames[0]);
    endtask

    task automatic test_register_reads();
        dac_word_t data;
        bus_read(reg_module_id, data);
        compare_word("reads module id", tb_module_id, data);
        bus_read(reg_module_version, data);
        compare_word("reads module version", 16'd1, data);
        bus_read(reg_dac, data);
        compare_word("reads dac word", tb_dac_default, data);
        bus_read(4'd9, data);
        compare_word("reads undefined address", 16'h0000, data);
    endtask

    task automatic test_host_write();
        dac_word_t word;
        dac_word_t data;
        int        count;
        set_owner(1'b1);
        for (int i = 0; i < 4; i++) begin
            word  = random_word();
            count = frames.size();
            bus_write(reg_dac, word);
            wait_updated();
            compare_count("host write frame count", count + 1, frames.size());
            compare_word("host write frame", word, frames[count]);
            bus_read(reg_dac, data);
            compare_word("host write readback", word, data);
        end
        // gain has no effect while the host owns the word
        count = frames.size();
        gain_pulse(8'hA5);
        check_no_update(100);
        compare_count("host owned gain frame count", count, frames.size());
        bus_read(reg_dac, data);
        compare_word("host owned gain readback", word, data);
    endtask

    task automatic test_gain_path();
        dac_word_t             base;
        dac_word_t             expected;
        dac_word_t             data;
        dac_word_t             rnd_word;
        power_mode_t           mode;
        logic [gain_width-1:0] g;
        int                    count;
        // host loads a known mode and reserved pattern first
        rnd_word = random_word();
        mode     = mode_pd_100k;
        base     = {mode, rnd_word[7:0], rnd_word[13:8]};
        bus_write(reg_dac, base);
        wait_updated();
        set_owner(1'b0);
        rnd_word       = random_word();
        g              = rnd_word[15:8];
        expected       = base;
        expected[13:6] = g;
        count          = frames.size();
        gain_pulse(g);
        wait_updated();
        compare_count("gain frame count", count + 1, frames.size());
        compare_word("gain frame", expected, frames[count]);
        bus_read(reg_dac, data);
        compare_word("gain readback", expected, data);
        // host writes are dropped while gain owns the word
        bus_write(reg_dac, ~expected);
        check_no_update(100);
        compare_count("ignored write frame count", count + 1, frames.size());
        bus_read(reg_dac, data);
        compare_word("ignored write readback", expected, data);
        bus_read(reg_mmi_ctrl, data);
        compare_word("mmi ctrl low readback", 16'h0000, data);
        set_owner(1'b1);
        bus_read(reg_mmi_ctrl, data);
        compare_word("mmi ctrl high readback", 16'h0001, data);
    endtask

    task automatic test_merge();
        dac_word_t words[4];
        dac_word_t data;
        int        count;
        foreach (words[i]) begin
            words[i] = random_word();
        end
        count = frames.size();
        bus_write(reg_dac, words[0]);
        wait_frame_active();
        // three writes inside one frame collapse into one follow-up
        for (int i = 1; i < 4; i++) begin
            bus_write(reg_dac, words[i]);
        end
        wait_updated();
        wait_updated();
        compare_count("merge frame count", count + 2, frames.size());
        compare_word("merge in-flight frame", words[0], frames[count]);
        compare_word("merge follow-up frame", words[3], frames[count + 1]);
        check_no_update(timeout_cycles);
        compare_count("merge no extra frame", count + 2, frames.size());
        bus_read(reg_dac, data);
        compare_word("merge readback", words[3], data);
    endtask

    initial begin
        SET_DEFAULT_ON_RESET = 1'b1;
        mmi_ctrl_en          = 1'b1;
        wr_stb               = 1'b0;
        wr_addr              = reg_module_id;
        wr_data              = '0;
        rd_stb               = 1'b0;
        rd_addr              = 4'd0;
        gain                 = '0;
        gain_valid_stb       = 1'b0;
        repeat (2) @(negedge clk_ifc);
        SET_DEFAULT_ON_RESET = 1'b0;

        test_reset_default();
        test_register_reads();
        test_host_write();
        test_gain_path();
        test_merge();

        if (UUT.u_spi.spi_checks.error_count == 0 &&
            UUT.u_sequencer.seq_checks.error_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("assertion failures were recorded");
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
source/dac_pkg.sv
source/dac_reg_map.sv
source/dac_update_sequencer.sv
source/spi_shift_master.sv
source/dac_ad5601_subsystem.sv
verification/dac_tb_assert.sv
verification/dac_tb.sv

//--- Makefile
# Verilator build and run for the AD5601 control block

VERILATOR ?= verilator
TB_TOP    ?= dac_tb
RTL_TOP   ?= dac_ad5601_subsystem
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
RUN_ARGS  ?= +verilator+error+limit+100

RTL_SRCS := $(filter source/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -o $(TB_TOP)

run: build
	./$(OBJ_DIR)/$(TB_TOP) $(RUN_ARGS)

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
